// File: cpu_config.svh
// ************************************************************************
// core-wide widths, memory depth, reset PC and the flush encoding
// include from any file that needs one of these values
// ************************************************************************
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data, address and instruction width
`define CPU_WORD_W 16

// instruction memory size in 16-bit words
`define CPU_IMEM_DEPTH 256

// byte address of the first fetch
`define CPU_RESET_PC 16'h0000

// opcode 00001 with zero fields, used to squash the wrong-path slot
`define CPU_NOP_INSTR 16'h0800

`endif

// File: cpu_pkg.sv
// ************************************************************************
// shared types for the core, imported by every module that uses them
// ************************************************************************
`default_nettype none
`include "cpu_config.svh"

package cpu_pkg;

   // data, PC and instruction words
   typedef logic [`CPU_WORD_W-1:0] word_t;

   // index into the eight-entry register file
   typedef logic [2:0] reg_addr_t;

   // word index into instruction memory, PC with bit 0 dropped
   typedef logic [$clog2(`CPU_IMEM_DEPTH)-1:0] imem_addr_t;

   // top five bits of the instruction
   typedef enum logic [4:0] {
      OP_HALT = 5'b00000,
      OP_NOP  = 5'b00001,
      OP_J    = 5'b00100,
      OP_JR   = 5'b00101,
      OP_JAL  = 5'b00110,
      OP_ADDI = 5'b01000,
      OP_BEQZ = 5'b01100,
      OP_BNEZ = 5'b01101,
      OP_LBI  = 5'b11000,
      OP_ALUR = 5'b11011
   } opcode_t;

   // function field of ALUR, bits 1..0
   typedef enum logic [1:0] {
      ALU_ADD = 2'b00,
      ALU_SUB = 2'b01,
      ALU_XOR = 2'b10,
      ALU_AND = 2'b11
   } alu_op_t;

endpackage

`default_nettype wire

// File: instr_mem.sv
// ************************************************************************
// instruction memory that fetch reads combinationally and the testbench
// loads through a clocked write port while the core is held in reset
// ************************************************************************
`timescale 1ns/100ps
`default_nettype none
`include "cpu_config.svh"

module instr_mem
   import cpu_pkg::*;
(
   input  wire        clk,
   input  logic       we,
   input  imem_addr_t wr_addr,
   input  word_t      wr_data,
   input  imem_addr_t rd_addr,
   output word_t      rd_data
);

   // program storage filled through the load port
   word_t mem [`CPU_IMEM_DEPTH];

   // load port
   always_ff @(posedge clk) begin
      if (we) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // asynchronous fetch read makes the word ready in the same cycle
   assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

// File: fetch.sv
// ************************************************************************
// stage 1 with the PC, PC+2, redirect and halt hold, and the fetch/decode
// register that feeds stage 2 (a NOP is injected on a taken transfer)
// ************************************************************************
`timescale 1ns/100ps
`default_nettype none
`include "cpu_config.svh"

module fetch
   import cpu_pkg::*;
(
   input  wire        clk,
   input  wire        reset,
   input  logic       redirect,
   input  word_t      target,
   input  logic       halted,
   output imem_addr_t imem_addr,
   input  word_t      imem_data,
   output word_t      if_instr,
   output word_t      if_pc2
);

   word_t pc;
   word_t pc_plus2;
   word_t pc_next;

   // sequential successor wraps at 16 bits
   assign pc_plus2 = pc + word_t'(2);

   // a taken branch or jump in stage 2 overrides the sequential PC
   assign pc_next = redirect ? target : pc_plus2;

   // byte PC to word index by dropping the always-zero bit 0
   assign imem_addr = imem_addr_t'(pc[$bits(imem_addr_t):1]);

   // PC register
   // halted holds it in place
   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= `CPU_RESET_PC;
      end else if (!halted) begin
         pc <= pc_next;
      end
   end

   // instruction register
   // the word fetched behind a taken transfer is on the wrong path,
   // so a NOP goes into stage 2 in its place
   always_ff @(posedge clk) begin
      if (reset) begin
         if_instr <= `CPU_NOP_INSTR;
      end else if (!halted) begin
         if_instr <= redirect ? `CPU_NOP_INSTR : imem_data;
      end
   end

   // PC+2 travels with the instruction for links and relative targets
   always_ff @(posedge clk) begin
      if (!halted) begin
         if_pc2 <= pc_plus2;
      end
   end

endmodule

`default_nettype wire

// File: decode.sv
// ************************************************************************
// stage 2 front half: field split, immediate forms, destination select
// and the 8 x 16 register file written from the writeback port
// ************************************************************************
`timescale 1ns/100ps
`default_nettype none

module decode
   import cpu_pkg::*;
(
   input  wire       clk,
   input  wire       reset,
   input  word_t     instr,
   input  logic      wb_en,
   input  reg_addr_t wb_reg,
   input  word_t     wb_data,
   output opcode_t   opcode,
   output alu_op_t   alu_op,
   output word_t     rs_val,
   output word_t     rt_val,
   output word_t     imm_ext,
   output reg_addr_t wr_reg
);

   reg_addr_t rs;
   reg_addr_t rt;
   reg_addr_t rd;
   word_t     imm5_ext;
   word_t     imm8_ext;
   word_t     disp11_ext;

   // register file
   word_t regs [8];

   // fixed field positions
   assign opcode = opcode_t'(instr[15:11]);
   assign alu_op = alu_op_t'(instr[1:0]);
   assign rs     = instr[10:8];
   assign rt     = instr[7:5];
   assign rd     = instr[4:2];

   // sign extension of the three immediate widths
   assign imm5_ext   = word_t'($signed(instr[4:0]));
   assign imm8_ext   = word_t'($signed(instr[7:0]));
   assign disp11_ext = word_t'($signed(instr[10:0]));

   // pick the immediate form by opcode
   always_comb begin
      case (opcode)
         OP_ADDI:                       imm_ext = imm5_ext;
         OP_LBI, OP_BEQZ, OP_BNEZ, OP_JR: imm_ext = imm8_ext;
         OP_J, OP_JAL:                  imm_ext = disp11_ext;
         default:                       imm_ext = '0;
      endcase
   end

   // destination register
   // JAL always links into r7
   always_comb begin
      case (opcode)
         OP_ALUR: wr_reg = rd;
         OP_ADDI: wr_reg = rt;
         OP_LBI:  wr_reg = rs;
         OP_JAL:  wr_reg = reg_addr_t'(7);
         default: wr_reg = rs;
      endcase
   end

   // read ports, combinational
   // a write lands at the edge that ends the cycle, after the read
   assign rs_val = regs[rs];
   assign rt_val = regs[rt];

   // write port driven by result
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_en) begin
         regs[wb_reg] <= wb_data;
      end
   end

endmodule

`default_nettype wire

// File: execute.sv
// ************************************************************************
// stage 2 middle: ALU, zero test, branch and jump targets, and the
// redirect level sent back to fetch
// ************************************************************************
`timescale 1ns/100ps
`default_nettype none

module execute
   import cpu_pkg::*;
(
   input  opcode_t opcode,
   input  alu_op_t alu_op,
   input  word_t   rs_val,
   input  word_t   rt_val,
   input  word_t   imm_ext,
   input  word_t   pc2,
   output word_t   alu_result,
   output logic    redirect,
   output word_t   target
);

   word_t alur_val;
   word_t pc_target;
   word_t reg_target;
   logic  rs_zero;

   // register-register ops, all sums wrap at 16 bits
   always_comb begin
      case (alu_op)
         ALU_ADD: alur_val = rs_val + rt_val;
         ALU_SUB: alur_val = rs_val - rt_val;
         ALU_XOR: alur_val = rs_val ^ rt_val;
         ALU_AND: alur_val = rs_val & rt_val;
         default: alur_val = '0;
      endcase
   end

   // value headed for writeback
   // LBI passes the extended byte straight through
   always_comb begin
      case (opcode)
         OP_ADDI: alu_result = rs_val + imm_ext;
         OP_LBI:  alu_result = imm_ext;
         OP_ALUR: alu_result = alur_val;
         default: alu_result = '0;
      endcase
   end

   // branches look only at rs
   assign rs_zero = (rs_val == '0);

   // relative form for branches, J and JAL
   assign pc_target = pc2 + imm_ext;

   // JR is rs plus imm8
   assign reg_target = rs_val + imm_ext;

   assign target = (opcode == OP_JR) ? reg_target : pc_target;

   // taken transfers
   // fetch also uses this to squash the shadow slot
   always_comb begin
      case (opcode)
         OP_J, OP_JAL, OP_JR: redirect = 1'b1;
         OP_BEQZ:             redirect = rs_zero;
         OP_BNEZ:             redirect = !rs_zero;
         default:             redirect = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

// File: result.sv
// ************************************************************************
// stage 2 back half: writeback enable and value, and the halted latch
// ************************************************************************
`timescale 1ns/100ps
`default_nettype none

module result
   import cpu_pkg::*;
(
   input  wire       clk,
   input  wire       reset,
   input  opcode_t   opcode,
   input  word_t     alu_result,
   input  word_t     pc2,
   input  reg_addr_t wr_reg,
   output logic      wb_en,
   output reg_addr_t wb_reg,
   output word_t     wb_data,
   output logic      halted
);

   logic writes_reg;

   // opcodes that produce a register result
   assign writes_reg = (opcode == OP_ADDI) || (opcode == OP_LBI) ||
                       (opcode == OP_ALUR) || (opcode == OP_JAL);

   // the instruction held behind HALT must not retire
   assign wb_en   = writes_reg && !halted;
   assign wb_reg  = wr_reg;
   // JAL links the return address
   assign wb_data = (opcode == OP_JAL) ? pc2 : alu_result;

   // sticky until reset
   always_ff @(posedge clk) begin
      if (reset) begin
         halted <= 1'b0;
      end else if (opcode == OP_HALT) begin
         halted <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: cpu_top.sv
// ************************************************************************
// core top: instruction memory plus the two stages, with the load port in
// and the writeback port and halted out for the testbench
// ************************************************************************
`timescale 1ns/100ps
`default_nettype none

module cpu_top
   import cpu_pkg::*;
(
   input  wire        clk,
   input  wire        reset,
   input  logic       imem_we,
   input  imem_addr_t imem_addr,
   input  word_t      imem_data,
   output logic       wb_en,
   output reg_addr_t  wb_reg,
   output word_t      wb_data,
   output logic       halted
);

   // fetch side of memory
   imem_addr_t fetch_addr;
   word_t      fetch_word;

   // stage 1 to stage 2
   word_t      if_instr;
   word_t      if_pc2;

   // decode to execute and result
   opcode_t    opcode;
   alu_op_t    alu_op;
   word_t      rs_val;
   word_t      rt_val;
   word_t      imm_ext;
   reg_addr_t  wr_reg;

   // execute outputs
   word_t      alu_result;
   logic       redirect;
   word_t      target;

   instr_mem u_imem (
      .clk(clk), .we(imem_we), .wr_addr(imem_addr), .wr_data(imem_data),
      .rd_addr(fetch_addr), .rd_data(fetch_word)
   );

   fetch u_fetch (
      .clk(clk), .reset(reset), .redirect(redirect), .target(target),
      .halted(halted), .imem_addr(fetch_addr), .imem_data(fetch_word),
      .if_instr(if_instr), .if_pc2(if_pc2)
   );

   decode u_decode (
      .clk(clk), .reset(reset), .instr(if_instr),
      .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
      .opcode(opcode), .alu_op(alu_op), .rs_val(rs_val), .rt_val(rt_val),
      .imm_ext(imm_ext), .wr_reg(wr_reg)
   );

   execute u_execute (
      .opcode(opcode), .alu_op(alu_op), .rs_val(rs_val), .rt_val(rt_val),
      .imm_ext(imm_ext), .pc2(if_pc2), .alu_result(alu_result),
      .redirect(redirect), .target(target)
   );

   result u_result (
      .clk(clk), .reset(reset), .opcode(opcode), .alu_result(alu_result),
      .pc2(if_pc2), .wr_reg(wr_reg), .wb_en(wb_en), .wb_reg(wb_reg),
      .wb_data(wb_data), .halted(halted)
   );

endmodule

`default_nettype wire

// File: tb_cpu.sv
// ************************************************************************
// directed and random tests for the core, every writeback is compared
// with a reference model that steps the program by the instruction rules
// ************************************************************************
`timescale 1ns/100ps
`default_nettype none
`include "cpu_config.svh"

module tb_cpu
   import cpu_pkg::*;
();

   localparam int HALT_TIMEOUT = 500;
   localparam int QUIET_CYCLES = 20;
   localparam word_t HALT_WORD = {OP_HALT, 11'd0};

   logic        clk;
   logic        reset;
   logic        imem_we;
   imem_addr_t  imem_addr;
   word_t       imem_data;
   logic        wb_en;
   reg_addr_t   wb_reg;
   word_t       wb_data;
   logic        halted;

   // program image and the writes the model expects from it
   word_t       prog [`CPU_IMEM_DEPTH];
   int          prog_len;
   reg_addr_t   exp_reg_q [$];
   word_t       exp_data_q [$];
   logic [31:0] rng_state;
   int          check_count;
   int          error_count;

   cpu_top dut (
      .clk(clk), .reset(reset), .imem_we(imem_we), .imem_addr(imem_addr),
      .imem_data(imem_data), .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
      .halted(halted)
   );

   always #5 clk = ~clk;

   // upper bits come from bit width-1 of the field
   function automatic word_t sign_ext(input word_t field, input int width);
      word_t mask;
      mask = word_t'(16'hFFFF << width);
      return field[width-1] ? (field | mask) : (field & ~mask);
   endfunction

   // assembler, one function per instruction format
   function automatic word_t alur_instr(input alu_op_t fn, input int rd, input int rs,
                                        input int rt);
      return {OP_ALUR, rs[2:0], rt[2:0], rd[2:0], fn};
   endfunction

   function automatic word_t addi_instr(input int rt, input int rs, input int imm);
      return {OP_ADDI, rs[2:0], rt[2:0], imm[4:0]};
   endfunction

   // LBI, BEQZ, BNEZ and JR
   function automatic word_t imm8_instr(input opcode_t op, input int rs, input int imm);
      return {op, rs[2:0], imm[7:0]};
   endfunction

   function automatic word_t jump_instr(input opcode_t op, input int disp);
      return {op, disp[10:0]};
   endfunction

   task automatic emit(input word_t w);
      prog[prog_len] = w;
      prog_len++;
   endtask

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_word(input string name, input word_t got, input word_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic report_failure(input string msg);
      error_count++;
      $display("%0t: %s", $time, msg);
   endtask

   // reference model, runs the image from the reset PC up to HALT
   // and queues every register write in order
   task automatic run_model();
      word_t     regs [8];
      word_t     pc;
      word_t     instr;
      word_t     rs_v;
      word_t     rt_v;
      word_t     imm8;
      word_t     val;
      reg_addr_t dst;
      opcode_t   op;
      logic      wr;
      logic      done;
      int        steps;
      exp_reg_q.delete();
      exp_data_q.delete();
      for (int i = 0; i < 8; i++) begin
         regs[i] = '0;
      end
      pc = `CPU_RESET_PC;
      done = 1'b0;
      for (steps = 0; steps < 1000 && !done; steps++) begin
         instr = prog[pc[$clog2(`CPU_IMEM_DEPTH):1]];
         op = opcode_t'(instr[15:11]);
         rs_v = regs[instr[10:8]];
         rt_v = regs[instr[7:5]];
         imm8 = sign_ext(instr, 8);
         // pc now holds PC+2
         pc = pc + 16'd2;
         wr = 1'b1;
         case (op)
            OP_ADDI: begin
               dst = instr[7:5];
               val = rs_v + sign_ext(instr, 5);
            end
            OP_LBI: begin
               dst = instr[10:8];
               val = imm8;
            end
            OP_ALUR: begin
               dst = instr[4:2];
               case (alu_op_t'(instr[1:0]))
                  ALU_ADD: val = rs_v + rt_v;
                  ALU_SUB: val = rs_v - rt_v;
                  ALU_XOR: val = rs_v ^ rt_v;
                  default: val = rs_v & rt_v;
               endcase
            end
            OP_JAL: begin
               dst = 3'd7;
               val = pc;
               pc = pc + sign_ext(instr, 11);
            end
            default: begin
               // control only, nothing written
               wr = 1'b0;
               if (op == OP_HALT) done = 1'b1;
               if (op == OP_J) pc = pc + sign_ext(instr, 11);
               if (op == OP_JR) pc = rs_v + imm8;
               if ((op == OP_BEQZ && rs_v == '0) || (op == OP_BNEZ && rs_v != '0)) begin
                  pc = pc + imm8;
               end
            end
         endcase
         if (wr) begin
            regs[dst] = val;
            exp_reg_q.push_back(dst);
            exp_data_q.push_back(val);
         end
      end
      if (!done) report_failure("model ran 1000 steps without reaching HALT");
   endtask

   // load the image under reset, release, then follow writebacks to halt
   task automatic run_program(input string name);
      int   wb_count;
      int   model_count;
      logic seen_halt;
      run_model();
      model_count = exp_reg_q.size();
      #1;
      reset = 1'b1;
      for (int i = 0; i < prog_len; i++) begin
         @(posedge clk);
         #1;
         imem_we = 1'b1;
         imem_addr = imem_addr_t'(i);
         imem_data = prog[i];
      end
      @(posedge clk);
      #1;
      imem_we = 1'b0;
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;
      wb_count = 0;
      seen_halt = 1'b0;
      // values sampled at the edge are those of the cycle it ends
      for (int cyc = 0; cyc < HALT_TIMEOUT && !seen_halt; cyc++) begin
         @(posedge clk);
         if (wb_en === 1'b1) begin
            wb_count++;
            if (exp_reg_q.size() == 0) begin
               report_failure($sformatf("%s: writeback to r%0d not expected", name, wb_reg));
            end else begin
               check_reg("wb_reg", wb_reg, exp_reg_q.pop_front());
               check_word("wb_data", wb_data, exp_data_q.pop_front());
            end
         end
         seen_halt = (halted === 1'b1);
      end
      if (!seen_halt) begin
         report_failure($sformatf("%s: halted did not rise in %0d cycles", name, HALT_TIMEOUT));
      end else begin
         // core must stay quiet and halted
         for (int cyc = 0; cyc < QUIET_CYCLES; cyc++) begin
            @(posedge clk);
            if (wb_en !== 1'b0 || halted !== 1'b1) begin
               report_failure($sformatf("%s: writeback or halted change after halt", name));
            end
         end
      end
      if (wb_count != model_count) begin
         report_failure($sformatf("%s: %0d writebacks seen, model made %0d",
                                  name, wb_count, model_count));
      end
   endtask

   task automatic alu_ops();
      prog_len = 0;
      emit(imm8_instr(OP_LBI, 1, 37));
      emit(imm8_instr(OP_LBI, 2, -13));
      emit(alur_instr(ALU_ADD, 3, 1, 2));
      emit(alur_instr(ALU_SUB, 4, 1, 2));
      emit(alur_instr(ALU_XOR, 5, 1, 2));
      emit(alur_instr(ALU_AND, 6, 1, 2));
      emit(alur_instr(ALU_SUB, 0, 2, 1));
      emit(HALT_WORD);
      run_program("alu");
   endtask

   // imm5 extremes and 16-bit wraparound
   task automatic addi_immediates();
      prog_len = 0;
      emit(imm8_instr(OP_LBI, 1, 64));
      emit(addi_instr(2, 1, -16));
      emit(addi_instr(3, 1, -1));
      emit(addi_instr(4, 1, 15));
      emit(imm8_instr(OP_LBI, 5, -1));
      emit(addi_instr(6, 5, 15));
      emit(addi_instr(0, 0, -16));
      emit(addi_instr(7, 5, 1));
      emit(HALT_WORD);
      run_program("addi");
   endtask

   // each branch skips one word when taken, shadows write only if untaken
   task automatic branch_shadows();
      prog_len = 0;
      emit(`CPU_NOP_INSTR);
      emit(imm8_instr(OP_LBI, 1, 0));
      emit(imm8_instr(OP_LBI, 2, 5));
      emit(imm8_instr(OP_BEQZ, 1, 2));
      emit(imm8_instr(OP_LBI, 3, 'h11));
      emit(imm8_instr(OP_LBI, 3, 'h22));
      emit(imm8_instr(OP_BNEZ, 1, 2));
      emit(imm8_instr(OP_LBI, 4, 'h33));
      emit(imm8_instr(OP_LBI, 4, 'h44));
      emit(imm8_instr(OP_BNEZ, 2, 2));
      emit(imm8_instr(OP_LBI, 5, 'h55));
      emit(imm8_instr(OP_LBI, 5, 'h66));
      emit(imm8_instr(OP_BEQZ, 2, 2));
      emit(imm8_instr(OP_LBI, 6, 'h77));
      emit(HALT_WORD);
      run_program("branch");
   endtask

   // byte addresses 0..28, HALT at 22 is reached by the backward J
   task automatic jumps_and_links();
      prog_len = 0;
      emit(imm8_instr(OP_LBI, 1, 'h10));
      emit(jump_instr(OP_J, 4));
      emit(imm8_instr(OP_LBI, 2, 'h99));
      emit(imm8_instr(OP_LBI, 2, 'h98));
      emit(jump_instr(OP_JAL, 6));
      emit(imm8_instr(OP_LBI, 3, 'h33));
      emit(imm8_instr(OP_LBI, 3, 'h34));
      emit(jump_instr(OP_J, 8));
      // subroutine at 16, returns to r7 + 2
      emit(imm8_instr(OP_LBI, 4, 'h44));
      emit(imm8_instr(OP_JR, 7, 2));
      emit(imm8_instr(OP_LBI, 5, 'h55));
      emit(HALT_WORD);
      emit(imm8_instr(OP_LBI, 6, 'h66));
      emit(jump_instr(OP_J, -6));
      emit(imm8_instr(OP_LBI, 6, 'h77));
      run_program("jump");
   endtask

   // writers parked behind HALT must never retire
   task automatic halt_quiet();
      prog_len = 0;
      emit(imm8_instr(OP_LBI, 1, 1));
      emit(HALT_WORD);
      emit(imm8_instr(OP_LBI, 2, 2));
      emit(addi_instr(3, 1, 1));
      run_program("halt");
   endtask

   task automatic random_program();
      logic [31:0] r;
      prog_len = 0;
      for (int n = 0; n < 40; n++) begin
         rng_state = lcg_step(rng_state);
         r = rng_state;
         case (r[17:16])
            2'd0: emit(imm8_instr(OP_LBI, int'(r[2:0]), int'(r[27:20])));
            2'd1: emit(addi_instr(int'(r[5:3]), int'(r[2:0]), int'(r[15:11])));
            default: emit(alur_instr(alu_op_t'(r[10:9]), int'(r[8:6]), int'(r[2:0]),
                                     int'(r[5:3])));
         endcase
      end
      emit(HALT_WORD);
      run_program("random");
   endtask

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      imem_we = 1'b0;
      imem_addr = '0;
      imem_data = '0;
      rng_state = 32'ha9f7_f46d;
      check_count = 0;
      error_count = 0;
      alu_ops();
      addi_immediates();
      branch_shadows();
      jumps_and_links();
      halt_quiet();
      random_program();
      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
cpu_pkg.sv
instr_mem.sv
fetch.sv
decode.sv
execute.sv
result.sv
cpu_top.sv
tb_cpu.sv

// File: Makefile
# Verilator lint and simulation of the core with its testbench
VERILATOR ?= verilator
FILELIST  ?= project.f
TOP       ?= tb_cpu
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# the run passes only if the pass line appears in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
